// ==== verilog/cache_settings.svh ====
//--------------------
// sizes and address field bounds of the read cache
// include in any file that needs a width or a depth
//--------------------
`ifndef CACHE_SETTINGS_SVH
`define CACHE_SETTINGS_SVH

`define CACHE_NUM_TQ_ENTRY     8
`define CACHE_NUM_SETS         64

// address fields
`define CACHE_LSB_BYTE_OFFSET  0
`define CACHE_MSB_BYTE_OFFSET  1
`define CACHE_LSB_WORD_OFFSET  2
`define CACHE_MSB_WORD_OFFSET  3
`define CACHE_LSB_SET          4
`define CACHE_MSB_SET          9
`define CACHE_LSB_TAG          10
`define CACHE_MSB_TAG          31

// data widths
`define CACHE_LINE_W           128
`define CACHE_WORD_W           32
`define CACHE_REG_ID_W         5

`endif

// ==== verilog/cache_param_pkg.sv ====
//--------------------
// types of the core and far memory ports of the read cache
//--------------------
`default_nettype none
`include "cache_settings.svh"

package cache_param_pkg;

    typedef logic [`CACHE_REG_ID_W-1:0]                             t_reg_id;
    typedef logic [$clog2(`CACHE_NUM_TQ_ENTRY)-1:0]                  t_tq_id;
    typedef logic [`CACHE_MSB_TAG-`CACHE_LSB_TAG:0]                  t_tag;
    typedef logic [`CACHE_MSB_SET-`CACHE_LSB_SET:0]                  t_set;
    typedef logic [`CACHE_MSB_TAG-`CACHE_LSB_SET:0]                  t_cl_address; // tag and set
    typedef logic [`CACHE_MSB_WORD_OFFSET-`CACHE_LSB_WORD_OFFSET:0]  t_word_offset;
    typedef logic [`CACHE_WORD_W-1:0]                                t_word;
    typedef logic [`CACHE_LINE_W-1:0]                                t_cl_data;

    typedef enum logic {
        RD_OP = 1'b0,
        WR_OP = 1'b1
    } t_opcode;

    typedef struct packed {
        t_tag                                                    tag;
        t_set                                                    set;
        t_word_offset                                            word_offset;
        logic [`CACHE_MSB_BYTE_OFFSET-`CACHE_LSB_BYTE_OFFSET:0]  byte_offset;
    } t_address_fields;

    // same address word, raw or split into its fields
    typedef union packed {
        logic [`CACHE_MSB_TAG:0] raw;
        t_address_fields         f;
    } t_address;

    typedef struct packed {
        logic     valid;
        t_opcode  opcode;
        t_reg_id  reg_id;
        t_address address;
        t_word    data;      // write data, not used by reads
    } t_req;

    typedef struct packed {
        logic     valid;
        t_address address;
        t_reg_id  reg_id;
        t_word    data;
    } t_rd_rsp;

    typedef struct packed {
        logic        valid;
        t_tq_id      tq_id;
        t_cl_address cl_address;
    } t_fm_rd_req;

    typedef struct packed {
        logic     valid;
        t_tq_id   tq_id;
        t_cl_data cl_data;
    } t_fm_rd_rsp;

endpackage

`default_nettype wire

// ==== verilog/cache_pipe_pkg.sv ====
//--------------------
// types between the transaction queue and the lookup pipe
//--------------------
`default_nettype none

package cache_pipe_pkg;

    typedef enum logic [1:0] {
        NO_LU,
        RD_LU,
        FILL_LU
    } t_lu_op;

    typedef enum logic [1:0] {
        HIT,
        MISS,
        FILL,
        REJECT
    } t_lu_result;

    typedef enum logic [2:0] {
        S_IDLE,
        S_LU_CORE,
        S_MB_WAIT_FILL,
        S_MB_FILL_READY,
        S_ERROR
    } t_tq_state;

    typedef struct packed {
        logic                        valid;
        t_lu_op                      lu_op;
        cache_param_pkg::t_tq_id     tq_id;
        cache_param_pkg::t_reg_id    reg_id;
        cache_param_pkg::t_address   address;
        cache_param_pkg::t_word      data;
        logic                        rd_indication;
    } t_lu_req;

    typedef struct packed {
        logic                        rd_miss;
        logic                        alloc_rd_fill;  // fill of an entry a core read is waiting on
        cache_param_pkg::t_tq_id     lu_tq_id;
        cache_param_pkg::t_cl_address cl_address;
    } t_early_lu_rsp;

    typedef struct packed {
        logic                        valid;
        t_lu_op                      lu_op;
        t_lu_result                  lu_result;
        cache_param_pkg::t_tq_id     tq_id;
        cache_param_pkg::t_reg_id    reg_id;
        cache_param_pkg::t_address   address;
        logic                        rd_indication;
        cache_param_pkg::t_cl_data   cl_data;
    } t_lu_rsp;

endpackage

`default_nettype wire

// ==== verilog/cache_tq.sv ====
//--------------------
// transaction queue of the read cache: tracks misses, feeds the lookup pipe
// and returns read data to the core
//--------------------
`timescale 1ns/1ps
`default_nettype none
`include "cache_settings.svh"

module cache_tq (
    input  logic                          clk,
    input  logic                          reset,
    // core
    input  cache_param_pkg::t_req         pre_core2cache_req,
    output logic                          stall,
    output cache_param_pkg::t_rd_rsp      cache2core_rsp,
    // far memory
    input  cache_param_pkg::t_fm_rd_rsp   fm2cache_rd_rsp,
    // lookup pipe
    output cache_pipe_pkg::t_lu_req       pipe_lu_req_q1,
    input  cache_pipe_pkg::t_early_lu_rsp pipe_early_lu_rsp_q2,
    input  cache_pipe_pkg::t_lu_rsp       pipe_lu_rsp_q3
);
    import cache_param_pkg::*;
    import cache_pipe_pkg::*;

    t_req         core2cache_req;      // core request after the reissue mux
    t_req         reissue_req;
    t_tq_id       rd_miss_tq_id;
    t_cl_address  rd_miss_cl_address;
    logic         set_rd_miss_was_filled;
    logic         rd_miss_was_filled;
    logic         sel_reissue;
    logic         stall_rd_miss_q;
    logic         tq_full;

    t_tq_state    tq_state         [`CACHE_NUM_TQ_ENTRY];
    t_tq_state    next_tq_state    [`CACHE_NUM_TQ_ENTRY];
    t_cl_address  tq_cl_address    [`CACHE_NUM_TQ_ENTRY];
    t_word_offset tq_word_offset   [`CACHE_NUM_TQ_ENTRY];
    t_reg_id      tq_reg_id        [`CACHE_NUM_TQ_ENTRY];
    logic         tq_rd_indication [`CACHE_NUM_TQ_ENTRY];
    logic [`CACHE_NUM_TQ_ENTRY-1:0] free_entries;

    logic         free_exists;
    logic         fill_exists;
    logic         error_exists;
    t_tq_id       enc_first_free;
    t_tq_id       enc_first_fill;
    logic         allocate;
    logic         issue_fill;

    //--------------------
    // reissue and read miss stall
    //--------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            reissue_req.valid <= 1'b0;
        end else if (pipe_early_lu_rsp_q2.rd_miss) begin
            reissue_req <= pre_core2cache_req;   // cancelled in q1, replayed after the fill
        end
    end

    always_ff @(posedge clk) begin
        if (pipe_early_lu_rsp_q2.rd_miss) begin
            rd_miss_tq_id      <= pipe_early_lu_rsp_q2.lu_tq_id;
            rd_miss_cl_address <= pipe_early_lu_rsp_q2.cl_address;
        end
    end

    // the fill of the stalling miss has passed q2
    assign set_rd_miss_was_filled = stall_rd_miss_q &&
                                    pipe_early_lu_rsp_q2.alloc_rd_fill &&
                                    (pipe_early_lu_rsp_q2.lu_tq_id == rd_miss_tq_id) &&
                                    (pipe_early_lu_rsp_q2.cl_address == rd_miss_cl_address);
    assign sel_reissue = rd_miss_was_filled && !fill_exists;

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_miss_was_filled <= 1'b0;
            stall_rd_miss_q    <= 1'b0;
        end else begin
            rd_miss_was_filled <= set_rd_miss_was_filled || (rd_miss_was_filled && !sel_reissue);
            stall_rd_miss_q    <= pipe_early_lu_rsp_q2.rd_miss ||
                                  (stall_rd_miss_q && !sel_reissue);
        end
    end

    assign core2cache_req = sel_reissue ? reissue_req : pre_core2cache_req;

    assign tq_full = ($countones(free_entries) <= 1);
    assign stall   = tq_full || stall_rd_miss_q || pipe_early_lu_rsp_q2.rd_miss;

    //--------------------
    // entry selection
    //--------------------
    always_comb begin
        free_exists    = 1'b0;
        fill_exists    = 1'b0;
        error_exists   = 1'b0;
        enc_first_free = '0;
        enc_first_fill = '0;
        for (int i = `CACHE_NUM_TQ_ENTRY - 1; i >= 0; i--) begin   // lowest index wins
            free_entries[i] = (tq_state[i] == S_IDLE);
            if (free_entries[i]) begin
                free_exists    = 1'b1;
                enc_first_free = t_tq_id'(i);
            end
            if (tq_state[i] == S_MB_FILL_READY) begin
                fill_exists    = 1'b1;
                enc_first_fill = t_tq_id'(i);
            end
            error_exists = error_exists || (tq_state[i] == S_ERROR);
        end
    end

    assign allocate   = core2cache_req.valid && free_exists && !pipe_early_lu_rsp_q2.rd_miss;
    assign issue_fill = !core2cache_req.valid && fill_exists;   // fills only in idle slots

    //--------------------
    // entry state
    //--------------------
    always_comb begin
        for (int i = 0; i < `CACHE_NUM_TQ_ENTRY; i++) begin
            next_tq_state[i] = tq_state[i];
            case (tq_state[i])
                S_IDLE: begin
                    if (allocate && (enc_first_free == t_tq_id'(i))) begin
                        next_tq_state[i] = (core2cache_req.opcode == RD_OP) ? S_LU_CORE : S_ERROR;
                    end
                end
                S_LU_CORE: begin
                    if (pipe_lu_rsp_q3.valid && (pipe_lu_rsp_q3.tq_id == t_tq_id'(i))) begin
                        case (pipe_lu_rsp_q3.lu_result)
                            HIT:     next_tq_state[i] = S_IDLE;
                            MISS:    next_tq_state[i] = S_MB_WAIT_FILL;
                            FILL:    next_tq_state[i] = S_LU_CORE;  // older fill of this slot
                            default: next_tq_state[i] = S_ERROR;
                        endcase
                    end
                end
                S_MB_WAIT_FILL: begin
                    if (fm2cache_rd_rsp.valid && (fm2cache_rd_rsp.tq_id == t_tq_id'(i))) begin
                        next_tq_state[i] = S_MB_FILL_READY;
                    end
                end
                S_MB_FILL_READY: begin
                    if (issue_fill && (enc_first_fill == t_tq_id'(i))) begin
                        next_tq_state[i] = S_IDLE;
                    end
                end
                default: next_tq_state[i] = tq_state[i];
            endcase
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < `CACHE_NUM_TQ_ENTRY; i++) begin
            tq_state[i] <= reset ? S_IDLE : next_tq_state[i];
        end
    end

    always_ff @(posedge clk) begin
        if (allocate) begin
            tq_cl_address[enc_first_free]    <= {core2cache_req.address.f.tag,
                                                 core2cache_req.address.f.set};
            tq_word_offset[enc_first_free]   <= core2cache_req.address.f.word_offset;
            tq_reg_id[enc_first_free]        <= core2cache_req.reg_id;
            tq_rd_indication[enc_first_free] <= (core2cache_req.opcode == RD_OP);
        end
    end

    //--------------------
    // pipe request mux
    //--------------------
    always_comb begin
        pipe_lu_req_q1 = '0;
        if (allocate) begin
            pipe_lu_req_q1.valid         = 1'b1;
            pipe_lu_req_q1.lu_op         = (core2cache_req.opcode == RD_OP) ? RD_LU : NO_LU;
            pipe_lu_req_q1.tq_id         = enc_first_free;
            pipe_lu_req_q1.reg_id        = core2cache_req.reg_id;
            pipe_lu_req_q1.address       = core2cache_req.address;
            pipe_lu_req_q1.data          = core2cache_req.data;
            pipe_lu_req_q1.rd_indication = (core2cache_req.opcode == RD_OP);
        end else if (issue_fill) begin
            pipe_lu_req_q1.valid         = 1'b1;
            pipe_lu_req_q1.lu_op         = FILL_LU;
            pipe_lu_req_q1.tq_id         = enc_first_fill;
            pipe_lu_req_q1.reg_id        = tq_reg_id[enc_first_fill];
            pipe_lu_req_q1.address.raw   = {tq_cl_address[enc_first_fill],
                                            tq_word_offset[enc_first_fill], 2'b00};
            pipe_lu_req_q1.rd_indication = tq_rd_indication[enc_first_fill];
        end
    end

    //--------------------
    // core response
    //--------------------
    assign cache2core_rsp.valid   = pipe_lu_rsp_q3.valid &&
                                    (((pipe_lu_rsp_q3.lu_op == RD_LU) &&
                                      (pipe_lu_rsp_q3.lu_result == HIT)) ||
                                     ((pipe_lu_rsp_q3.lu_op == FILL_LU) &&
                                      pipe_lu_rsp_q3.rd_indication));
    assign cache2core_rsp.address = pipe_lu_rsp_q3.address;
    assign cache2core_rsp.reg_id  = pipe_lu_rsp_q3.reg_id;
    assign cache2core_rsp.data    = pipe_lu_rsp_q3.cl_data[pipe_lu_rsp_q3.address.f.word_offset *
                                                           `CACHE_WORD_W +: `CACHE_WORD_W];

    // the core holds off a cycle after stall was seen
    a_no_req_in_stall: assert property (@(posedge clk) disable iff (reset)
        $past(stall) |-> !pre_core2cache_req.valid);

    // writes are not supported, so no entry may get stuck
    a_no_error_state: assert property (@(posedge clk) disable iff (reset) !error_exists);

endmodule

`default_nettype wire

// ==== verilog/cache_pipe.sv ====
//--------------------
// three stage lookup pipe: tag compare at q2, data read or fill write at q3
//--------------------
`timescale 1ns/1ps
`default_nettype none
`include "cache_settings.svh"

module cache_pipe (
    input  logic                          clk,
    input  logic                          reset,
    input  cache_pipe_pkg::t_lu_req       pipe_lu_req_q1,
    output cache_pipe_pkg::t_early_lu_rsp pipe_early_lu_rsp_q2,
    output cache_pipe_pkg::t_lu_rsp       pipe_lu_rsp_q3,
    input  cache_param_pkg::t_fm_rd_rsp   fm2cache_rd_rsp,
    output cache_param_pkg::t_fm_rd_req   cache2fm_rd_req
);
    import cache_param_pkg::*;
    import cache_pipe_pkg::*;

    t_lu_req    lu_req_q2;
    t_lu_req    lu_req_q3;
    t_lu_result lu_result_q2;
    t_lu_result lu_result_q3;
    logic       tag_hit_q2;
    logic       fill_q3;

    // direct mapped arrays
    t_tag     tag_array  [`CACHE_NUM_SETS];
    t_cl_data data_array [`CACHE_NUM_SETS];
    logic [`CACHE_NUM_SETS-1:0] valid_array;

    // one line per tq entry, loaded by FM and drained by the fill lookup
    t_cl_data fill_buf [`CACHE_NUM_TQ_ENTRY];
    logic [`CACHE_NUM_TQ_ENTRY-1:0] fill_loaded;

    //--------------------
    // stage registers
    //--------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            lu_req_q2.valid <= 1'b0;
            lu_req_q3.valid <= 1'b0;
        end else begin
            lu_req_q2 <= pipe_lu_req_q1;
            lu_req_q3 <= lu_req_q2;
        end
    end

    always_ff @(posedge clk) begin
        lu_result_q3 <= lu_result_q2;
    end

    //--------------------
    // q2 tag compare
    //--------------------
    assign tag_hit_q2 = valid_array[lu_req_q2.address.f.set] &&
                        (tag_array[lu_req_q2.address.f.set] == lu_req_q2.address.f.tag);

    always_comb begin
        case (lu_req_q2.lu_op)
            RD_LU:   lu_result_q2 = tag_hit_q2 ? HIT : MISS;
            FILL_LU: lu_result_q2 = FILL;
            default: lu_result_q2 = REJECT;   // non read op
        endcase
    end

    assign pipe_early_lu_rsp_q2.rd_miss       = lu_req_q2.valid && (lu_result_q2 == MISS);
    assign pipe_early_lu_rsp_q2.alloc_rd_fill = lu_req_q2.valid && (lu_req_q2.lu_op == FILL_LU) &&
                                                lu_req_q2.rd_indication;
    assign pipe_early_lu_rsp_q2.lu_tq_id      = lu_req_q2.tq_id;
    assign pipe_early_lu_rsp_q2.cl_address    = {lu_req_q2.address.f.tag,
                                                 lu_req_q2.address.f.set};

    //--------------------
    // q3 array access
    //--------------------
    assign fill_q3 = lu_req_q3.valid && (lu_req_q3.lu_op == FILL_LU);

    always_ff @(posedge clk) begin
        if (fill_q3) begin
            tag_array[lu_req_q3.address.f.set]  <= lu_req_q3.address.f.tag;
            data_array[lu_req_q3.address.f.set] <= fill_buf[lu_req_q3.tq_id];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_array <= '0;
        end else if (fill_q3) begin
            valid_array[lu_req_q3.address.f.set] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fm2cache_rd_rsp.valid) begin
            fill_buf[fm2cache_rd_rsp.tq_id] <= fm2cache_rd_rsp.cl_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            fill_loaded <= '0;
        end else begin
            if (fill_q3) begin
                fill_loaded[lu_req_q3.tq_id] <= 1'b0;
            end
            if (fm2cache_rd_rsp.valid) begin
                fill_loaded[fm2cache_rd_rsp.tq_id] <= 1'b1;
            end
        end
    end

    assign pipe_lu_rsp_q3.valid         = lu_req_q3.valid;
    assign pipe_lu_rsp_q3.lu_op         = lu_req_q3.lu_op;
    assign pipe_lu_rsp_q3.lu_result     = lu_result_q3;
    assign pipe_lu_rsp_q3.tq_id         = lu_req_q3.tq_id;
    assign pipe_lu_rsp_q3.reg_id        = lu_req_q3.reg_id;
    assign pipe_lu_rsp_q3.address       = lu_req_q3.address;
    assign pipe_lu_rsp_q3.rd_indication = lu_req_q3.rd_indication;
    assign pipe_lu_rsp_q3.cl_data       = fill_q3 ? fill_buf[lu_req_q3.tq_id]
                                                  : data_array[lu_req_q3.address.f.set];

    // one FM read per miss, sent from q3
    assign cache2fm_rd_req.valid      = lu_req_q3.valid && (lu_result_q3 == MISS);
    assign cache2fm_rd_req.tq_id      = lu_req_q3.tq_id;
    assign cache2fm_rd_req.cl_address = {lu_req_q3.address.f.tag, lu_req_q3.address.f.set};

    // TQ only issues a fill once FM has answered that entry
    a_fill_buf_loaded: assert property (@(posedge clk) disable iff (reset)
        fill_q3 |-> fill_loaded[lu_req_q3.tq_id]);

    // FM answers an entry once per miss
    a_no_fill_buf_overwrite: assert property (@(posedge clk) disable iff (reset)
        fm2cache_rd_rsp.valid |-> !fill_loaded[fm2cache_rd_rsp.tq_id]);

endmodule

`default_nettype wire

// ==== verilog/cache.sv ====
//--------------------
// read cache top, joins the transaction queue and the lookup pipe
//--------------------
`timescale 1ns/1ps
`default_nettype none

module cache (
    input  logic                        clk,
    input  logic                        reset,
    input  cache_param_pkg::t_req       pre_core2cache_req,
    output logic                        stall,
    output cache_param_pkg::t_rd_rsp    cache2core_rsp,
    output cache_param_pkg::t_fm_rd_req cache2fm_rd_req,
    input  cache_param_pkg::t_fm_rd_rsp fm2cache_rd_rsp
);
    import cache_pipe_pkg::*;

    t_lu_req       pipe_lu_req_q1;
    t_early_lu_rsp pipe_early_lu_rsp_q2;
    t_lu_rsp       pipe_lu_rsp_q3;

    cache_tq cache_tq_i (
        .clk                  (clk),
        .reset                (reset),
        .pre_core2cache_req   (pre_core2cache_req),
        .stall                (stall),
        .cache2core_rsp       (cache2core_rsp),
        .fm2cache_rd_rsp      (fm2cache_rd_rsp),
        .pipe_lu_req_q1       (pipe_lu_req_q1),
        .pipe_early_lu_rsp_q2 (pipe_early_lu_rsp_q2),
        .pipe_lu_rsp_q3       (pipe_lu_rsp_q3)
    );

    cache_pipe cache_pipe_i (
        .clk                  (clk),
        .reset                (reset),
        .pipe_lu_req_q1       (pipe_lu_req_q1),
        .pipe_early_lu_rsp_q2 (pipe_early_lu_rsp_q2),
        .pipe_lu_rsp_q3       (pipe_lu_rsp_q3),
        .fm2cache_rd_rsp      (fm2cache_rd_rsp),
        .cache2fm_rd_req      (cache2fm_rd_req)
    );

endmodule

`default_nettype wire

// ==== tests/cache_tb_clk.sv ====
//--------------------
// free running testbench clock, 4 ns period
//--------------------
`timescale 1ns/1ps
`default_nettype none

module cache_tb_clk (
    output logic clk
);
    localparam int HALF_PERIOD_NS = 2;

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD_NS) clk = ~clk;
    end

endmodule

`default_nettype wire

// ==== tests/cache_tb.sv ====
//--------------------
// testbench of the read cache: random reads scored against a residency model,
// with a far memory that answers each miss after a random delay
//--------------------
`timescale 1ns/1ps
`default_nettype none
`include "cache_settings.svh"

module cache_tb;
    import cache_param_pkg::*;

    localparam int NUM_READS   = 400;
    localparam int STALL_LIMIT = 200;     // cycles
    localparam int DRAIN_LIMIT = 200;
    localparam int RUN_LIMIT   = 40000;

    typedef struct packed {
        t_reg_id  reg_id;
        t_address address;
        logic     has_due;    // predicted hit, response time known
        int       due;
        logic     parked;     // cancelled by a q2 miss, replayed later
        logic     fm_seen;
    } t_expect;

    typedef struct packed {
        t_cl_address line;
        int          due;     // cycle of the FM request
    } t_miss_wait;

    typedef struct packed {
        t_tq_id      tq_id;
        t_cl_address line;
        int          due;
    } t_fm_pending;

    logic        clk;
    logic        reset;
    t_req        core_req;
    logic        stall;
    t_rd_rsp     core_rsp;
    t_fm_rd_req  fm_req;
    t_fm_rd_rsp  fm_rsp = '0;

    t_expect     exp_q[$];
    t_miss_wait  miss_q[$];
    t_fm_pending fm_q[$];
    t_tag        model_tag   [`CACHE_NUM_SETS];
    logic        model_valid [`CACHE_NUM_SETS];
    int          cycle        = 0;
    int          fm_cycle     = 0;
    int          reset_edges  = 0;
    int          hit_count    = 0;
    int          parked_count = 0;
    int          fm_count     = 0;
    logic        stall_checked = 1'b0;
    logic        stall_at_edge = 1'b1;   // stall as it stands up to the next edge

    cache_tb_clk cache_tb_clk_i (
        .clk (clk)
    );

    cache cache_i (
        .clk                (clk),
        .reset              (reset),
        .pre_core2cache_req (core_req),
        .stall              (stall),
        .cache2core_rsp     (core_rsp),
        .cache2fm_rd_req    (fm_req),
        .fm2cache_rd_rsp    (fm_rsp)
    );

    //--------------------
    // memory rule and residency model
    //--------------------
    function automatic t_word word_data(input logic [29:0] word_addr);
        return {2'b00, word_addr} ^ 32'hA5A5_0000;
    endfunction

    function automatic t_cl_data line_data(input t_cl_address line);
        t_cl_data data;
        for (int w = 0; w < 4; w++) begin
            data[w*`CACHE_WORD_W +: `CACHE_WORD_W] = word_data({line, 2'(w)});
        end
        return data;
    endfunction

    function automatic t_cl_address cl_address_of(input t_address address);
        return {address.f.tag, address.f.set};
    endfunction

    function automatic logic is_cached(input t_cl_address line);
        return model_valid[t_set'(line)] && (model_tag[t_set'(line)] == t_tag'(line >> 6));
    endfunction

    task automatic install_line(input t_cl_address line);
        model_valid[t_set'(line)] = 1'b1;
        model_tag[t_set'(line)]   = t_tag'(line >> 6);   // direct mapped, old tag is lost
    endtask

    // 4 tags x 8 sets x 4 words, so lines conflict within a set
    function automatic t_req random_read();
        t_req req;
        req                       = '0;
        req.valid                 = 1'b1;
        req.opcode                = RD_OP;
        req.reg_id                = t_reg_id'($urandom);
        req.address.f.tag         = t_tag'(22'h2a5 + $urandom_range(0, 3) * 22'h13);
        req.address.f.set         = t_set'($urandom_range(0, 7) * 8 + 2);
        req.address.f.word_offset = t_word_offset'($urandom_range(0, 3));
        return req;
    endfunction

    //--------------------
    // failure reporting
    //--------------------
    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_equal(input string what, input logic [127:0] actual,
                               input logic [127:0] expected);
        if (actual !== expected) begin
            $display("[ERROR] %0t %s: got %0h, expected %0h", $time, what, actual, expected);
            abort_run("value mismatch");
        end
    endtask

    //--------------------
    // monitor, samples mid cycle where all values are settled
    //--------------------
    task automatic note_fm_request();
        logic found;
        found = 1'b0;
        if (fm_req.valid) begin
            check_equal("fm request to a cached line", is_cached(fm_req.cl_address), 1'b0);
            check_equal("stall during a miss", stall, 1'b1);
            if ((miss_q.size() > 0) && (miss_q[0].due == cycle)) begin
                check_equal("fm request line", fm_req.cl_address, miss_q[0].line);
                void'(miss_q.pop_front());
            end else begin
                foreach (exp_q[i]) begin      // replayed read that missed
                    if (!found && exp_q[i].parked && !exp_q[i].fm_seen &&
                        (cl_address_of(exp_q[i].address) == fm_req.cl_address)) begin
                        exp_q[i].fm_seen = 1'b1;
                        found            = 1'b1;
                    end
                end
                check_equal("fm request matches a parked read", found, 1'b1);
            end
            install_line(fm_req.cl_address);
            fm_count++;
        end
        if ((miss_q.size() > 0) && (miss_q[0].due < cycle)) begin
            abort_run("a read miss sent no far memory request");
        end
    endtask

    task automatic score_response();
        t_expect head;
        if (core_rsp.valid) begin
            if (exp_q.size() == 0) begin
                abort_run("core response with no read outstanding");
            end
            head = exp_q.pop_front();
            check_equal("response reg_id", core_rsp.reg_id, head.reg_id);
            check_equal("response address", core_rsp.address, head.address);
            check_equal("response data", core_rsp.data, word_data(head.address.raw[31:2]));
            if (head.has_due) begin
                check_equal("hit latency", cycle, head.due);
            end
        end
        if ((exp_q.size() > 0) && exp_q[0].has_due && (exp_q[0].due < cycle)) begin
            abort_run("a read hit was not answered in time");
        end
    endtask

    task automatic log_core_request();
        t_expect    entry;
        t_miss_wait miss;
        if (core_req.valid) begin
            entry         = '0;
            entry.reg_id  = core_req.reg_id;
            entry.address = core_req.address;
            // the previous read missed and sits in q2 now
            if (stall && (miss_q.size() > 0) && (miss_q[$].due == cycle + 1)) begin
                entry.parked = 1'b1;
                parked_count++;
            end else if (is_cached(cl_address_of(core_req.address))) begin
                entry.has_due = 1'b1;
                entry.due     = cycle + 2;
                hit_count++;
            end else begin
                miss.line = cl_address_of(core_req.address);
                miss.due  = cycle + 2;
                miss_q.push_back(miss);
            end
            exp_q.push_back(entry);
        end
    endtask

    always @(negedge clk) begin
        cycle++;
        stall_at_edge = stall;
        if (reset) begin
            if (reset_edges > 0) begin
                check_equal("core response during reset", core_rsp.valid, 1'b0);
                check_equal("fm request during reset", fm_req.valid, 1'b0);
                check_equal("stall during reset", stall, 1'b0);
            end
            reset_edges++;
        end else begin
            if (!stall_checked) begin
                check_equal("stall after reset", stall, 1'b0);
                stall_checked = 1'b1;
            end
            note_fm_request();
            score_response();
            log_core_request();
        end
    end

    // far memory, answers after 1 to 12 cycles
    always @(negedge clk) begin
        t_fm_pending pend;
        fm_cycle++;
        if (!reset && fm_req.valid) begin
            pend.tq_id = fm_req.tq_id;
            pend.line  = fm_req.cl_address;
            pend.due   = fm_cycle + int'($urandom_range(1, 12));
            fm_q.push_back(pend);
        end
    end

    always @(posedge clk) begin
        t_fm_pending pend;
        #1;
        fm_rsp = '0;
        if ((fm_q.size() > 0) && (fm_q[0].due <= fm_cycle + 1)) begin
            pend           = fm_q.pop_front();
            fm_rsp.valid   = 1'b1;
            fm_rsp.tq_id   = pend.tq_id;
            fm_rsp.cl_data = line_data(pend.line);
        end
    end

    //--------------------
    // stimulus
    //--------------------
    task automatic idle_cycle();
        #1;
        core_req.valid = 1'b0;
        @(posedge clk);
    endtask

    initial begin
        int   gap;
        int   waited;
        t_req next_req;
        gap      = int'($urandom(32'h208));   // seeds the generator
        reset    = 1'b1;
        core_req = '0;
        for (int s = 0; s < `CACHE_NUM_SETS; s++) begin
            model_valid[s] = 1'b0;
        end
        repeat (16) @(posedge clk);
        #1;
        reset = 1'b0;
        for (int n = 0; n < NUM_READS; n++) begin
            gap      = ($urandom_range(0, 2) == 0) ? int'($urandom_range(1, 4)) : 0;
            next_req = random_read();
            @(posedge clk);
            repeat (gap) idle_cycle();
            waited = 0;
            while (stall_at_edge) begin       // stall as seen at this edge
                waited++;
                if (waited > STALL_LIMIT) begin
                    abort_run("core was stalled too long");
                end
                idle_cycle();
            end
            #1;
            core_req = next_req;
        end
        @(posedge clk);
        idle_cycle();
        #1;
        waited = 0;
        while (exp_q.size() != 0) begin
            waited++;
            if (waited > DRAIN_LIMIT) begin
                abort_run("reads were left unanswered at the end");
            end
            @(posedge clk);
            #1;
        end
        repeat (20) @(posedge clk);           // stray responses would show here
        #1;
        $display("reads %0d, hits %0d, parked %0d, fm requests %0d",
                 NUM_READS, hit_count, parked_count, fm_count);
        if ((exp_q.size() == 0) && (miss_q.size() == 0) && (fm_q.size() == 0)) begin
            $display("TEST RESULT: PASS");
            $finish;
        end else begin
            abort_run("requests were left outstanding at the end");
        end
    end

    // overall limit on the run
    initial begin
        for (int i = 0; i < RUN_LIMIT; i++) begin
            @(posedge clk);
        end
        abort_run("run did not finish within the cycle limit");
    end

endmodule

`default_nettype wire

// ==== cache.f ====
+incdir+verilog
verilog/cache_param_pkg.sv
verilog/cache_pipe_pkg.sv
verilog/cache_tq.sv
verilog/cache_pipe.sv
verilog/cache.sv
tests/cache_tb_clk.sv
tests/cache_tb.sv
